// ==== Makefile ====
# Verilator flow for the bounding box pipeline

TB_TOP := raster_bbox_tb
PASS   := Test completed successfully

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wall -f build.f --top-module raster_bbox

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TB_TOP) \
		-o sim_$(TB_TOP)
	@out="$$(./obj_dir/sim_$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+logic
logic/bbox_fixed_pkg.sv
logic/bbox_msaa_pkg.sv
logic/bbox_extent_stage.sv
logic/bbox_snap_stage.sv
logic/bbox_clip_stage.sv
logic/raster_bbox.sv
dv/raster_bbox_tb.sv

// ==== dv/raster_bbox_tb.sv ====
// ----------------------------------------------------------------------
// Testbench for the bounding box pipeline
// Table of triangles with expected boxes, random halt, in-order scoreboard
// ----------------------------------------------------------------------
`timescale 1ns/1ps

`include "bbox_defines.svh"

module raster_bbox_tb import bbox_fixed_pkg::*, bbox_msaa_pkg::*; ();

    // One triangle with its configuration and expected result
    typedef struct packed {
        vert_coords_t x;
        vert_coords_t y;
        coord_t       scr_x;
        coord_t       scr_y;
        msaa_mode_t   mode;
        coord_t       ll_x;
        coord_t       ll_y;
        coord_t       ur_x;
        coord_t       ur_y;
        logic         valid;
        logic         use_halt;
    } row_t;

    logic         clk;
    logic         reset;
    logic         halt;
    logic         in_valid;
    vert_coords_t tri_x;
    vert_coords_t tri_y;
    coord_t       screen_x;
    coord_t       screen_y;
    msaa_mode_t   msaa_mode;
    vert_coords_t out_tri_x;
    vert_coords_t out_tri_y;
    coord_t       box_ll_x;
    coord_t       box_ll_y;
    coord_t       box_ur_x;
    coord_t       box_ur_y;
    logic         out_valid;

    row_t         rows[$];
    int           pend_row[$];
    int           pend_load[$];
    int           cur_row = 0;
    int           exp_valid_rows = 0;
    int           valid_seen = 0;
    int           loads = 0;
    int           cycles = 0;
    int           limit = 0;
    int           errors = 0;
    int           checks = 0;
    logic [15:0]  lfsr = 16'd28003;

    // Output snapshot from the previous falling edge
    logic         held_halt = 1'b0;
    logic         last_valid;
    coord_t       last_ll_x;
    coord_t       last_ll_y;
    coord_t       last_ur_x;
    coord_t       last_ur_y;
    vert_coords_t last_tri_x;
    vert_coords_t last_tri_y;

    raster_bbox raster_bbox_inst (
        .clk, .reset, .halt, .in_valid, .tri_x, .tri_y,
        .screen_x, .screen_y, .msaa_mode,
        .out_tri_x, .out_tri_y,
        .box_ll_x, .box_ll_y, .box_ur_x, .box_ur_y,
        .out_valid
    );

    // 8 ns clock
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // Whole pixels plus a fraction in 1/1024 steps
    function automatic coord_t fx(int pix, int frac);
        return coord_t'(pix * (1 << `BBOX_RADIX) + frac);
    endfunction

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check(input logic [71:0] actual, input logic [71:0] expected,
                         input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("mismatch at %0t: %s, got %0h, expected %0h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic add_row(input coord_t x0, input coord_t x1, input coord_t x2,
                           input coord_t y0, input coord_t y1, input coord_t y2,
                           input msaa_mode_t mode, input int sx, input int sy,
                           input coord_t ll_x, input coord_t ll_y,
                           input coord_t ur_x, input coord_t ur_y,
                           input logic valid, input logic use_halt);
        row_t r;
        r.x        = {x2, x1, x0};
        r.y        = {y2, y1, y0};
        r.scr_x    = fx(sx, 0);
        r.scr_y    = fx(sy, 0);
        r.mode     = mode;
        r.ll_x     = ll_x;
        r.ll_y     = ll_y;
        r.ur_x     = ur_x;
        r.ur_y     = ur_y;
        r.valid    = valid;
        r.use_halt = use_halt;
        rows.push_back(r);
        if (valid) begin
            exp_valid_rows++;
        end
    endtask

    // Expected corners are the min/max floored to the grid, then clamped
    task automatic build_table;
        // 1x on screen with whole-pixel floor
        add_row(fx(10, 300), fx(50, 900), fx(30, 0), fx(20, 100), fx(5, 1000), fx(60, 512),
                msaa_1x, 640, 480, fx(10, 0), fx(5, 0), fx(50, 0), fx(60, 0), 1, 0);
        add_row(fx(100, 0), fx(200, 1), fx(150, 1023), fx(100, 0), fx(120, 0), fx(300, 77),
                msaa_1x, 640, 480, fx(100, 0), fx(100, 0), fx(200, 0), fx(300, 0), 1, 0);
        // ll_x floors back onto the right edge, so it is kept
        add_row(fx(640, 600), fx(645, 0), fx(650, 0), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_1x, 640, 480, fx(640, 0), fx(10, 0), fx(640, 0), fx(30, 0), 1, 0);
        // Wholly left, below, right, above
        add_row(fx(-50, 0), fx(-10, 0), fx(-1, 500), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 0);
        add_row(fx(10, 0), fx(20, 0), fx(30, 0), fx(-30, 0), fx(-20, 0), fx(-5, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 0);
        add_row(fx(641, 0), fx(700, 0), fx(650, 0), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 0);
        add_row(fx(10, 0), fx(20, 0), fx(30, 0), fx(481, 0), fx(490, 0), fx(500, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 0);
        // 4x keeps the half-pixel bit
        add_row(fx(3, 600), fx(7, 300), fx(4, 0), fx(2, 1000), fx(9, 700), fx(5, 100),
                msaa_4x, 640, 480, fx(3, 512), fx(2, 512), fx(7, 0), fx(9, 512), 1, 0);
        add_row(fx(-3, 700), fx(700, 0), fx(100, 0), fx(-1, 1000), fx(50, 0), fx(500, 300),
                msaa_4x, 640, 480, 0, 0, fx(640, 0), fx(480, 0), 1, 0);
        // 16x quarter pixels
        add_row(fx(11, 900), fx(12, 300), fx(13, 257), fx(4, 255), fx(6, 511), fx(8, 767),
                msaa_16x, 640, 480, fx(11, 768), fx(4, 0), fx(13, 256), fx(8, 512), 1, 0);
        add_row(fx(-20, 0), fx(-8, 0), fx(-1, 900), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_16x, 640, 480, 0, 0, 0, 0, 0, 0);
        // 64x eighth pixels
        add_row(fx(20, 127), fx(21, 1023), fx(22, 200), fx(30, 383), fx(31, 640), fx(33, 900),
                msaa_64x, 640, 480, fx(20, 0), fx(30, 256), fx(22, 128), fx(33, 896), 1, 0);
        add_row(fx(-1, 1023), fx(10, 0), fx(639, 1000), fx(-5, 0), fx(479, 950), fx(200, 0),
                msaa_64x, 640, 480, 0, 0, fx(639, 896), fx(479, 896), 1, 0);
        // Smaller screen clamps upper-right
        add_row(fx(10, 0), fx(400, 0), fx(100, 0), fx(5, 0), fx(300, 0), fx(7, 0),
                msaa_1x, 320, 240, fx(10, 0), fx(5, 0), fx(320, 0), fx(240, 0), 1, 0);
        // Same kinds of rows again under random halt
        add_row(fx(10, 300), fx(50, 900), fx(30, 0), fx(20, 100), fx(5, 1000), fx(60, 512),
                msaa_1x, 640, 480, fx(10, 0), fx(5, 0), fx(50, 0), fx(60, 0), 1, 1);
        add_row(fx(100, 0), fx(200, 1), fx(150, 1023), fx(100, 0), fx(120, 0), fx(300, 77),
                msaa_1x, 640, 480, fx(100, 0), fx(100, 0), fx(200, 0), fx(300, 0), 1, 1);
        add_row(fx(641, 0), fx(700, 0), fx(650, 0), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 1);
        add_row(fx(640, 600), fx(645, 0), fx(650, 0), fx(10, 0), fx(20, 0), fx(30, 0),
                msaa_1x, 640, 480, fx(640, 0), fx(10, 0), fx(640, 0), fx(30, 0), 1, 1);
        add_row(fx(0, 0), fx(639, 1023), fx(320, 5), fx(0, 0), fx(0, 0), fx(479, 1023),
                msaa_1x, 640, 480, fx(0, 0), fx(0, 0), fx(639, 0), fx(479, 0), 1, 1);
        add_row(fx(10, 0), fx(20, 0), fx(30, 0), fx(481, 0), fx(490, 0), fx(500, 0),
                msaa_1x, 640, 480, 0, 0, 0, 0, 0, 1);
        add_row(fx(-100, 0), fx(1000, 0), fx(5, 0), fx(-100, 0), fx(6, 0), fx(1000, 0),
                msaa_1x, 640, 480, 0, 0, fx(640, 0), fx(480, 0), 1, 1);
        add_row(fx(1, 1), fx(2, 2), fx(3, 3), fx(4, 4), fx(5, 5), fx(6, 6),
                msaa_1x, 640, 480, fx(1, 0), fx(4, 0), fx(3, 0), fx(6, 0), 1, 1);
    endtask

    // Offer one row until it is taken, draining first on a config change
    task automatic apply_row(input int idx);
        row_t r;
        logic h;
        int   halts;
        r     = rows[idx];
        halts = 0;
        if (idx == 0 || r.scr_x != rows[idx-1].scr_x || r.scr_y != rows[idx-1].scr_y ||
            r.mode != rows[idx-1].mode) begin
            @(posedge clk);
            in_valid <= 1'b0;
            halt     <= 1'b0;
            // Last triangle leaves the clip stage before config moves
            repeat (2) @(posedge clk);
        end
        do begin
            h = 1'b0;
            if (r.use_halt && halts < 3) begin
                lfsr = lfsr_next(lfsr);
                h    = lfsr[0];
            end
            if (h) begin
                halts++;
            end
            @(posedge clk);
            cur_row = idx;
            tri_x     <= r.x;
            tri_y     <= r.y;
            screen_x  <= r.scr_x;
            screen_y  <= r.scr_y;
            msaa_mode <= r.mode;
            in_valid  <= 1'b1;
            halt      <= h;
        end while (h);
    endtask

    // Pop the oldest expected triangle and compare
    task automatic take_output;
        int r;
        int due;
        if (pend_row.size() == 0) begin
            errors++;
            $display("out_valid rose at %0t with no triangle in flight", $time);
        end else begin
            r   = pend_row.pop_front();
            due = pend_load.pop_front();
            check(72'(loads), 72'(due), $sformatf("latency of row %0d", r));
            check(72'(box_ll_x), 72'(rows[r].ll_x), $sformatf("box_ll_x of row %0d", r));
            check(72'(box_ll_y), 72'(rows[r].ll_y), $sformatf("box_ll_y of row %0d", r));
            check(72'(box_ur_x), 72'(rows[r].ur_x), $sformatf("box_ur_x of row %0d", r));
            check(72'(box_ur_y), 72'(rows[r].ur_y), $sformatf("box_ur_y of row %0d", r));
            check(out_tri_x, rows[r].x, $sformatf("out_tri_x of row %0d", r));
            check(out_tri_y, rows[r].y, $sformatf("out_tri_y of row %0d", r));
        end
    endtask

    // Outputs are read on the falling edge
    // loads counts edges on which the pipeline moved
    always @(negedge clk) begin
        if (!reset) begin
            if (held_halt) begin
                check(72'(out_valid), 72'(last_valid), "out_valid held in halt");
                check(72'(box_ll_x), 72'(last_ll_x), "box_ll_x held in halt");
                check(72'(box_ll_y), 72'(last_ll_y), "box_ll_y held in halt");
                check(72'(box_ur_x), 72'(last_ur_x), "box_ur_x held in halt");
                check(72'(box_ur_y), 72'(last_ur_y), "box_ur_y held in halt");
                check(out_tri_x, last_tri_x, "out_tri_x held in halt");
                check(out_tri_y, last_tri_y, "out_tri_y held in halt");
            end else begin
                loads++;
                if (out_valid) begin
                    valid_seen++;
                    take_output();
                end
            end
            // Taken at the next edge and out three loads later
            if (in_valid && !halt && rows[cur_row].valid) begin
                pend_row.push_back(cur_row);
                pend_load.push_back(loads + 3);
            end
        end
        held_halt  = halt;
        last_valid = out_valid;
        last_ll_x  = box_ll_x;
        last_ll_y  = box_ll_y;
        last_ur_x  = box_ur_x;
        last_ur_y  = box_ur_y;
        last_tri_x = out_tri_x;
        last_tri_y = out_tri_y;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, pipeline did not deliver every box", limit);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        build_table();
        limit = rows.size() * 8 + 40;
        reset     <= 1'b1;
        halt      <= 1'b0;
        in_valid  <= 1'b0;
        tri_x     <= '0;
        tri_y     <= '0;
        screen_x  <= '0;
        screen_y  <= '0;
        msaa_mode <= msaa_1x;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        // Nothing offered yet, valid must stay low
        repeat (4) begin
            @(negedge clk);
            check(72'(out_valid), 72'(0), "out_valid before first triangle");
        end
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        halt     <= 1'b0;
        while (pend_row.size() != 0) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        check(72'(valid_seen), 72'(exp_valid_rows), "count of valid outputs");
        $display("errors %0d, checks %0d", errors, checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== logic/bbox_clip_stage.sv ====
// ----------------------------------------------------------------------
// Stage 3 of the bounding box pipeline
// Clamps the box to the screen and drops triangles wholly off screen
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module bbox_clip_stage import bbox_fixed_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  coord_t       screen_x,
    input  coord_t       screen_y,
    input  vert_coords_t snap_tri_x,
    input  vert_coords_t snap_tri_y,
    input  coord_t       snap_ll_x,
    input  coord_t       snap_ll_y,
    input  coord_t       snap_ur_x,
    input  coord_t       snap_ur_y,
    input  logic         snap_valid,
    output vert_coords_t out_tri_x,
    output vert_coords_t out_tri_y,
    output coord_t       box_ll_x,
    output coord_t       box_ll_y,
    output coord_t       box_ur_x,
    output coord_t       box_ur_y,
    output logic         out_valid
);

    // Box lies wholly left, below, right or above the screen
    logic   off_screen;

    // Clamped corners ahead of the register
    coord_t clip_ll_x;
    coord_t clip_ll_y;
    coord_t clip_ur_x;
    coord_t clip_ur_y;

    // Any one edge test is enough to reject
    assign off_screen = (snap_ur_x < 0)        ||
                        (snap_ur_y < 0)        ||
                        (snap_ll_x > screen_x) ||
                        (snap_ll_y > screen_y);

    // Lower-left raised to the origin
    assign clip_ll_x = (snap_ll_x < 0) ? '0 : snap_ll_x;
    assign clip_ll_y = (snap_ll_y < 0) ? '0 : snap_ll_y;

    // Upper-right lowered to the screen edge
    assign clip_ur_x = (snap_ur_x > screen_x) ? screen_x : snap_ur_x;
    assign clip_ur_y = (snap_ur_y > screen_y) ? screen_y : snap_ur_y;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else if (!halt) begin
            out_valid <= snap_valid && !off_screen;
        end
    end

    // Rejected triangles still load payload and only valid is dropped
    always_ff @(posedge clk) begin
        if (!halt) begin
            out_tri_x <= snap_tri_x;
            out_tri_y <= snap_tri_y;
            box_ll_x  <= clip_ll_x;
            box_ll_y  <= clip_ll_y;
            box_ur_x  <= clip_ur_x;
            box_ur_y  <= clip_ur_y;
        end
    end

    // Live box is inside the screen and well ordered
    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (box_ll_x >= 0) && (box_ll_x <= screen_x) &&
                      (box_ur_x >= 0) && (box_ur_x <= screen_x) &&
                      (box_ll_y >= 0) && (box_ll_y <= screen_y) &&
                      (box_ur_y >= 0) && (box_ur_y <= screen_y));

    assert property (@(posedge clk) disable iff (reset)
        out_valid |-> (box_ll_x <= box_ur_x) && (box_ll_y <= box_ur_y));

endmodule

// ==== logic/bbox_defines.svh ====
// ----------------------------------------------------------------------
// Bounding-box fixed-point parameters
// Coordinate widths and triangle size shared by packages and stages
// ----------------------------------------------------------------------
`ifndef BBOX_DEFINES_SVH
`define BBOX_DEFINES_SVH

// Total bits of a signed coordinate
// Integer part sits in [SIGFIG-1:RADIX]
`define BBOX_SIGFIG 24

// Fraction bits below the pixel boundary
// One pixel step is 1 << RADIX
`define BBOX_RADIX 10

// Vertices per triangle
// Extent search walks this many entries per axis
`define BBOX_VERTS 3

`endif

// ==== logic/bbox_extent_stage.sv ====
// ----------------------------------------------------------------------
// Stage 1 of the bounding box pipeline
// Finds the signed x/y extent of a triangle and registers it
// ----------------------------------------------------------------------
`timescale 1ns/1ps

`include "bbox_defines.svh"

module bbox_extent_stage import bbox_fixed_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  logic         in_valid,
    input  vert_coords_t tri_x,
    input  vert_coords_t tri_y,
    output vert_coords_t ext_tri_x,
    output vert_coords_t ext_tri_y,
    output coord_t       ext_ll_x,
    output coord_t       ext_ll_y,
    output coord_t       ext_ur_x,
    output coord_t       ext_ur_y,
    output logic         ext_valid
);

    // Running extent of the incoming triangle
    coord_t lo_x;
    coord_t lo_y;
    coord_t hi_x;
    coord_t hi_y;

    // Start from vertex 0 and sweep the rest
    // Casts keep every compare signed
    always_comb begin
        lo_x = coord_t'(tri_x[0]);
        hi_x = coord_t'(tri_x[0]);
        lo_y = coord_t'(tri_y[0]);
        hi_y = coord_t'(tri_y[0]);
        for (int v = 1; v < `BBOX_VERTS; v++) begin
            if (coord_t'(tri_x[v]) < lo_x) begin
                lo_x = coord_t'(tri_x[v]);
            end
            if (coord_t'(tri_x[v]) > hi_x) begin
                hi_x = coord_t'(tri_x[v]);
            end
            if (coord_t'(tri_y[v]) < lo_y) begin
                lo_y = coord_t'(tri_y[v]);
            end
            if (coord_t'(tri_y[v]) > hi_y) begin
                hi_y = coord_t'(tri_y[v]);
            end
        end
    end

    // Valid bit is cleared by reset even during halt
    always_ff @(posedge clk) begin
        if (reset) begin
            ext_valid <= 1'b0;
        end else if (!halt) begin
            ext_valid <= in_valid;
        end
    end

    // Payload register frozen while halted
    always_ff @(posedge clk) begin
        if (!halt) begin
            ext_tri_x <= tri_x;
            ext_tri_y <= tri_y;
            ext_ll_x  <= lo_x;
            ext_ll_y  <= lo_y;
            ext_ur_x  <= hi_x;
            ext_ur_y  <= hi_y;
        end
    end

    // Lower-left never passes upper-right on a live triangle
    assert property (@(posedge clk) disable iff (reset)
        ext_valid |-> (ext_ll_x <= ext_ur_x) && (ext_ll_y <= ext_ur_y));

endmodule

// ==== logic/bbox_fixed_pkg.sv ====
// ----------------------------------------------------------------------
// Fixed-point coordinate types for the bounding-box pipeline
// ----------------------------------------------------------------------
`include "bbox_defines.svh"

package bbox_fixed_pkg;

    // Signed coordinate in two's complement
    // Upper bits hold whole pixels, lower RADIX bits the fraction
    typedef logic signed [`BBOX_SIGFIG-1:0] coord_t;

    // One axis of a triangle, all x or all y
    // Entry 0 is the first vertex
    // Elements keep the signedness of coord_t
    typedef coord_t [`BBOX_VERTS-1:0] vert_coords_t;

    // Packed view is SIGFIG * VERTS bits
    // 72 bits for the default widths
    // Vertex v sits in bits [v*SIGFIG +: SIGFIG]

    // Both axes travel side by side as two ports
    // No struct carries them together
    // Sample-test stage downstream reads them from the last register
    // Screen dimensions also use coord_t
    // so clamping compares like with like

endpackage

// ==== logic/bbox_msaa_pkg.sv ====
// ----------------------------------------------------------------------
// MSAA subsample mode and the fraction mask used to snap box corners
// ----------------------------------------------------------------------
`include "bbox_defines.svh"

package bbox_msaa_pkg;

    // Samples per pixel
    // Encoding equals the number of fraction bits kept after snapping
    typedef enum logic [1:0] {
        msaa_1x  = 2'd0,
        msaa_4x  = 2'd1,
        msaa_16x = 2'd2,
        msaa_64x = 2'd3
    } msaa_mode_t;

    // Mask over the fraction bits of a coordinate
    // 1x keeps none and snaps to whole pixels
    // 4x keeps the half-pixel bit
    // 16x keeps the top two bits for quarter pixels
    // 64x keeps the top three bits for eighth pixels
    function automatic logic [`BBOX_RADIX-1:0] snap_mask(msaa_mode_t mode);
        logic [`BBOX_RADIX-1:0] low_ones;
        // Ones below the kept bits
        low_ones = {`BBOX_RADIX{1'b1}} >> mode;
        // Invert so only the top bits survive
        return ~low_ones;
    endfunction

    // ANDing the fraction with this mask floors the value
    // toward negative infinity in two's complement
    // Integer bits are never touched

endpackage

// ==== logic/bbox_snap_stage.sv ====
// ----------------------------------------------------------------------
// Stage 2 of the bounding box pipeline
// Floors both box corners onto the MSAA sample grid
// ----------------------------------------------------------------------
`timescale 1ns/1ps

`include "bbox_defines.svh"

module bbox_snap_stage import bbox_fixed_pkg::*, bbox_msaa_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  msaa_mode_t   msaa_mode,
    input  vert_coords_t ext_tri_x,
    input  vert_coords_t ext_tri_y,
    input  coord_t       ext_ll_x,
    input  coord_t       ext_ll_y,
    input  coord_t       ext_ur_x,
    input  coord_t       ext_ur_y,
    input  logic         ext_valid,
    output vert_coords_t snap_tri_x,
    output vert_coords_t snap_tri_y,
    output coord_t       snap_ll_x,
    output coord_t       snap_ll_y,
    output coord_t       snap_ur_x,
    output coord_t       snap_ur_y,
    output logic         snap_valid
);

    // Width of one whole pixel in fixed point
    localparam coord_t pixel_step = coord_t'(1 << `BBOX_RADIX);

    // Fraction bits that survive for the current mode
    logic [`BBOX_RADIX-1:0] frac_mask;

    // Corners after flooring
    coord_t grid_ll_x;
    coord_t grid_ll_y;
    coord_t grid_ur_x;
    coord_t grid_ur_y;

    assign frac_mask = snap_mask(msaa_mode);

    // Integer part passes, fraction is masked
    // Sign lives in the integer part so negatives floor downward
    assign grid_ll_x = {ext_ll_x[`BBOX_SIGFIG-1:`BBOX_RADIX], ext_ll_x[`BBOX_RADIX-1:0] & frac_mask};
    assign grid_ll_y = {ext_ll_y[`BBOX_SIGFIG-1:`BBOX_RADIX], ext_ll_y[`BBOX_RADIX-1:0] & frac_mask};
    assign grid_ur_x = {ext_ur_x[`BBOX_SIGFIG-1:`BBOX_RADIX], ext_ur_x[`BBOX_RADIX-1:0] & frac_mask};
    assign grid_ur_y = {ext_ur_y[`BBOX_SIGFIG-1:`BBOX_RADIX], ext_ur_y[`BBOX_RADIX-1:0] & frac_mask};

    always_ff @(posedge clk) begin
        if (reset) begin
            snap_valid <= 1'b0;
        end else if (!halt) begin
            snap_valid <= ext_valid;
        end
    end

    // Vertices ride along untouched
    always_ff @(posedge clk) begin
        if (!halt) begin
            snap_tri_x <= ext_tri_x;
            snap_tri_y <= ext_tri_y;
            snap_ll_x  <= grid_ll_x;
            snap_ll_y  <= grid_ll_y;
            snap_ur_x  <= grid_ur_x;
            snap_ur_y  <= grid_ur_y;
        end
    end

    // Snapped corner sits at or below its stage 1 value
    // and within one pixel of it
    property floor_within_pixel(coord_t raw, coord_t snapped);
        @(posedge clk) disable iff (reset)
        (ext_valid && !halt) |=> (snapped <= $past(raw)) && ($past(raw) - snapped < pixel_step);
    endproperty

    assert property (floor_within_pixel(ext_ll_x, snap_ll_x));
    assert property (floor_within_pixel(ext_ll_y, snap_ll_y));
    assert property (floor_within_pixel(ext_ur_x, snap_ur_x));
    assert property (floor_within_pixel(ext_ur_y, snap_ur_y));

endmodule

// ==== logic/raster_bbox.sv ====
// ----------------------------------------------------------------------
// Bounding box block of the rasterizer
// Extent, grid snap and screen clip as a three-cycle pipeline
// ----------------------------------------------------------------------
`timescale 1ns/1ps

module raster_bbox import bbox_fixed_pkg::*, bbox_msaa_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         halt,
    input  logic         in_valid,
    input  vert_coords_t tri_x,
    input  vert_coords_t tri_y,
    input  coord_t       screen_x,
    input  coord_t       screen_y,
    input  msaa_mode_t   msaa_mode,
    output vert_coords_t out_tri_x,
    output vert_coords_t out_tri_y,
    output coord_t       box_ll_x,
    output coord_t       box_ll_y,
    output coord_t       box_ur_x,
    output coord_t       box_ur_y,
    output logic         out_valid
);

    // Stage 1 to stage 2
    vert_coords_t ext_tri_x;
    vert_coords_t ext_tri_y;
    coord_t       ext_ll_x;
    coord_t       ext_ll_y;
    coord_t       ext_ur_x;
    coord_t       ext_ur_y;
    logic         ext_valid;

    // Stage 2 to stage 3
    vert_coords_t snap_tri_x;
    vert_coords_t snap_tri_y;
    coord_t       snap_ll_x;
    coord_t       snap_ll_y;
    coord_t       snap_ur_x;
    coord_t       snap_ur_y;
    logic         snap_valid;

    // Min/max extent of the raw vertices
    bbox_extent_stage extent_inst (
        .clk, .reset, .halt, .in_valid, .tri_x, .tri_y,
        .ext_tri_x, .ext_tri_y,
        .ext_ll_x, .ext_ll_y, .ext_ur_x, .ext_ur_y,
        .ext_valid
    );

    // Floor to the subsample grid
    bbox_snap_stage snap_inst (
        .clk, .reset, .halt, .msaa_mode,
        .ext_tri_x, .ext_tri_y,
        .ext_ll_x, .ext_ll_y, .ext_ur_x, .ext_ur_y,
        .ext_valid,
        .snap_tri_x, .snap_tri_y,
        .snap_ll_x, .snap_ll_y, .snap_ur_x, .snap_ur_y,
        .snap_valid
    );

    // Clamp to screen, reject off-screen boxes
    bbox_clip_stage clip_inst (
        .clk, .reset, .halt, .screen_x, .screen_y,
        .snap_tri_x, .snap_tri_y,
        .snap_ll_x, .snap_ll_y, .snap_ur_x, .snap_ur_y,
        .snap_valid,
        .out_tri_x, .out_tri_y,
        .box_ll_x, .box_ll_y, .box_ur_x, .box_ur_y,
        .out_valid
    );

endmodule
